// ==== logic/obj_draw.sv ====
/* Object graphics fetcher and pixel writer
   Graphics ROM must answer exactly one cycle after gfx_addr, at most 32 words per object */
`timescale 1ns/10ps

module obj_draw import obj_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    draw_cmd_if.slave             cmd,
    output logic [17:0]           gfx_addr,
    input  logic [15:0]           gfx_data,
    output logic                  wr_en,
    output logic [8:0]            wr_x,
    output logic [LINE_PIX_W-1:0] wr_pix
);

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_WAIT = 3'd1;  // First word still in flight
    localparam logic [2:0] ST_LOAD = 3'd2;
    localparam logic [2:0] ST_PIX  = 3'd3;  // Four pixels per word
    localparam logic [2:0] ST_END  = 3'd4;

    logic [2:0]  st;
    logic [14:0] gaddr;
    logic [15:0] word;
    logic [1:0]  pcnt;
    logic [4:0]  wcnt;
    logic [8:0]  x;
    logic [1:0]  nib;
    logic [3:0]  pix;
    logic        flip;
    logic        word_end;

    assign flip     = cmd.offset.fields.flip;
    assign gfx_addr = {cmd.bank, gaddr};
    assign nib      = flip ? pcnt : ~pcnt;          // Flip reads low nibble first
    assign pix      = word[{nib, 2'b00} +: 4];
    assign word_end = (pcnt == 2'd3);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= ST_IDLE;
            cmd.busy <= 1'b0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (st)
                ST_IDLE: if (cmd.start) begin
                    cmd.busy <= 1'b1;
                    st       <= ST_WAIT;
                end
                ST_WAIT: st <= ST_LOAD;
                ST_LOAD: st <= ST_PIX;
                ST_PIX: begin
                    if (pix == PIX_END) begin
                        st <= ST_END;
                    end else begin
                        wr_en <= (pix != 4'd0);     // Zero is transparent
                        if (word_end) st <= (wcnt == 5'd31) ? ST_END : ST_LOAD;
                    end
                end
                ST_END: begin
                    cmd.busy <= 1'b0;   // Last write lands on this edge
                    st       <= ST_IDLE;
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            ST_IDLE: begin
                gaddr <= cmd.offset.fields.addr;
                x     <= cmd.xpos;
                wcnt  <= 5'd0;
            end
            ST_LOAD: begin
                word  <= gfx_data;
                pcnt  <= 2'd0;
                gaddr <= flip ? gaddr - 1'b1 : gaddr + 1'b1;    // Next word requested now
            end
            ST_PIX: begin
                wr_x   <= x;
                wr_pix <= {cmd.prio, cmd.pal, pix};
                x      <= x + 1'b1;     // Skipped pixels still move x
                pcnt   <= pcnt + 1'b1;
                if (word_end) wcnt <= wcnt + 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/obj_ifs.sv ====
/* Table port and draw command bundles
   Table read data lags the address by one cycle */
`timescale 1ns/10ps

interface tbl_if #(parameter int AW = 10) ();
    logic [AW-1:0] addr;
    logic [15:0]   dout;    // Valid one cycle after addr
    logic [15:0]   din;
    logic          we;      // Writes din at addr on this edge

    modport master (output addr, din, we, input dout);
    modport slave  (input addr, din, we, output dout);
endinterface

interface draw_cmd_if import obj_pkg::*; ();
    logic        start;     // One cycle, only while busy is low
    logic        busy;
    logic [8:0]  xpos;
    obj_offset_u offset;
    logic [2:0]  bank;
    logic [1:0]  prio;
    logic [5:0]  pal;

    // Fields held by the scanner until the next start
    modport master (output start, xpos, offset, bank, prio, pal, input busy);
    modport slave  (input start, xpos, offset, bank, prio, pal, output busy);
endinterface

// ==== logic/obj_line_buf.sv ====
/* One-line pixel store, first writer wins, read clears the entry
   A write and a read of the same x in one cycle lose the write */
`timescale 1ns/10ps

module obj_line_buf import obj_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  logic [8:0]            wr_x,
    input  logic [LINE_PIX_W-1:0] wr_pix,
    input  logic                  rd_en,
    input  logic [8:0]            rd_x,
    output logic [LINE_PIX_W-1:0] rd_pix
);

    logic [LINE_PIX_W-1:0] mem [512];
    logic [511:0]          vld;        // Entry holds a pixel
    logic                  wr_ok;

    assign wr_ok = wr_en && !vld[wr_x];    // Earlier table entry keeps the spot

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld <= '0;      // Whole line empty
        end else begin
            if (wr_ok) vld[wr_x] <= 1'b1;
            if (rd_en) vld[rd_x] <= 1'b0;   // Clear on read
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_x] <= wr_pix;
        end
        if (rd_en) begin
            rd_pix <= vld[rd_x] ? mem[rd_x] : '0;
        end
    end

endmodule

// ==== logic/obj_pkg.sv ====
/* Shared constants for the object line engine
   Table word layout assumes eight 16-bit words per object, words 5 to 7 unused */
package obj_pkg;

    localparam logic [8:0] LAST_LINE = 9'd223;    // Last visible line
    localparam logic [7:0] END_MARK  = 8'hF0;     // Bottom byte above this ends the list

    // Word index inside one object entry
    localparam logic [2:0] W_LINES  = 3'd0;       // Top byte, bottom byte
    localparam logic [2:0] W_XPOS   = 3'd1;
    localparam logic [2:0] W_PITCH  = 3'd2;
    localparam logic [2:0] W_OFFSET = 3'd3;
    localparam logic [2:0] W_ATTR   = 3'd4;       // Palette 13:8, bank 6:4, prio 1:0

    localparam logic [3:0] PIX_END    = 4'hF;     // Terminates the graphics
    localparam int         LINE_PIX_W = 12;       // Prio, palette, pixel

    // Offset word, summed as a number or split for the fetcher
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic        flip;
            logic [14:0] addr;
        } fields;
    } obj_offset_u;

endpackage

// ==== logic/obj_scan.sv ====
/* Per-line object table walker, one draw command per covering object
   Line compare uses the low 8 bits of vrender only */
`timescale 1ns/10ps

module obj_scan import obj_pkg::*; #(
    parameter int OBJ_AW = 7
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       hstart,
    input  logic [8:0] vrender,
    tbl_if.master      tbl,
    draw_cmd_if.master cmd,
    output logic       line_done
);

    localparam logic [3:0] ST_IDLE   = 4'd0;
    localparam logic [3:0] ST_FETCH  = 4'd1;    // Lines word address out
    localparam logic [3:0] ST_LINES  = 4'd2;
    localparam logic [3:0] ST_XPOS   = 4'd3;
    localparam logic [3:0] ST_PITCH  = 4'd4;
    localparam logic [3:0] ST_OFFSET = 4'd5;
    localparam logic [3:0] ST_ATTR   = 4'd6;
    localparam logic [3:0] ST_ISSUE  = 4'd7;    // Write-back edge, then wait on busy
    localparam logic [3:0] ST_DONE   = 4'd8;

    logic [3:0]        st;
    logic [OBJ_AW-1:0] obj;
    logic [2:0]        idx;
    logic [7:0]        line;
    logic              first;       // Object top is this line
    logic [8:0]        xpos;
    logic signed [15:0] pitch;
    obj_offset_u       offset;
    logic [15:0]       attr;        // Held until issue, drawer may still be busy
    logic [7:0]        top;
    logic [7:0]        bottom;
    logic              last_obj;

    assign tbl.addr = {obj, idx};
    assign tbl.din  = offset.raw;
    assign top      = tbl.dout[15:8];
    assign bottom   = tbl.dout[7:0];
    assign last_obj = (obj == {OBJ_AW{1'b1}});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= ST_IDLE;
            obj       <= '0;
            idx       <= W_LINES;
            tbl.we    <= 1'b0;
            cmd.start <= 1'b0;
            line_done <= 1'b0;
        end else begin
            cmd.start <= 1'b0;
            line_done <= 1'b0;
            tbl.we    <= 1'b0;
            case (st)
                ST_IDLE: if (hstart && vrender <= LAST_LINE) st <= ST_FETCH;
                ST_FETCH: begin
                    idx <= W_XPOS;
                    st  <= ST_LINES;
                end
                ST_LINES: begin
                    idx <= W_PITCH;
                    st  <= ST_XPOS;
                    if (bottom > END_MARK) begin
                        st <= ST_DONE;          // End of list
                    end else if (top > line || bottom < line) begin
                        idx <= W_LINES;         // Not on this line
                        obj <= obj + 1'b1;
                        st  <= last_obj ? ST_DONE : ST_FETCH;
                    end
                end
                ST_XPOS: begin
                    idx <= W_OFFSET;
                    st  <= ST_PITCH;
                end
                ST_PITCH: begin
                    idx <= W_ATTR;
                    st  <= ST_OFFSET;
                end
                ST_OFFSET: begin
                    idx <= W_OFFSET;            // Address held for write-back
                    st  <= ST_ATTR;
                end
                ST_ATTR: begin
                    tbl.we <= !first;           // Top line keeps the stored offset
                    st     <= ST_ISSUE;
                end
                ST_ISSUE: if (!cmd.busy) begin
                    cmd.start <= 1'b1;
                    idx       <= W_LINES;
                    obj       <= obj + 1'b1;
                    st        <= last_obj ? ST_DONE : ST_FETCH;
                end
                ST_DONE: begin
                    obj <= '0;
                    idx <= W_LINES;
                    if (!cmd.busy && !cmd.start) begin  // Drawer finished too
                        line_done <= 1'b1;
                        st        <= ST_IDLE;
                    end
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    // Object fields and command payload
    always_ff @(posedge clk) begin
        if (st == ST_IDLE) line <= vrender[7:0];
        if (st == ST_LINES) first <= (top == line);
        if (st == ST_XPOS) xpos <= tbl.dout[8:0];
        if (st == ST_PITCH) pitch <= tbl.dout;
        if (st == ST_OFFSET) begin
            offset.raw <= first ? tbl.dout : tbl.dout + pitch;  // Advance by pitch
        end
        if (st == ST_ATTR) attr <= tbl.dout;
        if (st == ST_ISSUE && !cmd.busy) begin
            cmd.xpos   <= xpos;
            cmd.offset <= offset;
            cmd.pal    <= attr[13:8];
            cmd.bank   <= attr[6:4];
            cmd.prio   <= attr[1:0];
        end
    end

endmodule

// ==== logic/obj_table_ram.sv ====
/* Object table memory, CPU write port plus scanner read/write port
   CPU and scanner must not write the same cycle, CPU writes only in vblank */
`timescale 1ns/10ps

module obj_table_ram #(
    parameter int OBJ_AW = 7
) (
    input  logic              clk,
    input  logic              cpu_we,
    input  logic [OBJ_AW+2:0] cpu_addr,
    input  logic [15:0]       cpu_din,
    tbl_if.slave              tbl
);

    localparam int DEPTH = 8 * (2 ** OBJ_AW);   // Eight words per object

    logic [15:0] mem [DEPTH];

    // One array, both writers in one process
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;   // Table load from the CPU
        end
        if (tbl.we) begin
            mem[tbl.addr] <= tbl.din;   // Offset write-back
        end
        tbl.dout <= mem[tbl.addr];      // Old data on read-during-write
    end

endmodule

// ==== logic/obj_top.sv ====
/* Object line engine top level
   CPU table writes only during vertical blank, readout one cycle after rd_en */
`timescale 1ns/10ps

module obj_top import obj_pkg::*; #(
    parameter int OBJ_AW = 7
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hstart,
    input  logic [8:0]            vrender,
    input  logic                  cpu_we,
    input  logic [OBJ_AW+2:0]     cpu_addr,
    input  logic [15:0]           cpu_din,
    output logic [17:0]           gfx_addr,
    input  logic [15:0]           gfx_data,
    input  logic                  rd_en,
    input  logic [8:0]            rd_x,
    output logic [LINE_PIX_W-1:0] rd_pix,
    output logic                  line_done
);

    logic                  wr_en;
    logic [8:0]            wr_x;
    logic [LINE_PIX_W-1:0] wr_pix;

    tbl_if #(.AW(OBJ_AW + 3)) tbl ();
    draw_cmd_if cmd ();

    obj_table_ram #(.OBJ_AW(OBJ_AW)) u_ram (
        .clk, .cpu_we, .cpu_addr, .cpu_din, .tbl(tbl.slave)
    );

    obj_scan #(.OBJ_AW(OBJ_AW)) u_scan (
        .clk, .rst, .hstart, .vrender, .tbl(tbl.master), .cmd(cmd.master), .line_done
    );

    obj_draw u_draw (
        .clk, .rst, .cmd(cmd.slave), .gfx_addr, .gfx_data, .wr_en, .wr_x, .wr_pix
    );

    obj_line_buf u_buf (
        .clk, .rst, .wr_en, .wr_x, .wr_pix, .rd_en, .rd_x, .rd_pix
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the object line engine testbench with Verilator, run it, judge by the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module obj_tb -f src.f -o obj_sim
./obj_dir/obj_sim | tee sim.log
grep -q "All checks passed" sim.log

// ==== src.f ====
logic/obj_pkg.sv
logic/obj_ifs.sv
logic/obj_table_ram.sv
logic/obj_scan.sv
logic/obj_draw.sv
logic/obj_line_buf.sv
logic/obj_top.sv
testbench/obj_asserts.sv
testbench/obj_tb.sv

// ==== testbench/obj_asserts.sv ====
/* Concurrent checks on the draw command and the line buffer write port
   Bound into the drawer, which sees the scanner's start through the command bundle */
`timescale 1ns/10ps

module obj_asserts import obj_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  start,
    input logic                  busy,
    input logic                  wr_en,
    input logic [LINE_PIX_W-1:0] wr_pix
);

    // Commands only go to an idle drawer
    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("draw start while drawer busy");

    a_start_pulse: assert property (@(posedge clk) disable iff (rst) start |=> !start)
        else $error("draw start held longer than one cycle");

    // End code stops drawing, never stored
    a_no_end_pix: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (wr_pix[3:0] != PIX_END))
        else $error("end pixel written to line buffer");

endmodule

bind obj_draw obj_asserts draw_chk (
    .clk(clk), .rst(rst), .start(cmd.start), .busy(cmd.busy), .wr_en(wr_en), .wr_pix(wr_pix)
);

// ==== testbench/obj_patterns.txt ====
// @000 table: lines, xpos, pitch, offset, attr, 3 unused per object; @100 ROM word at gfx_addr
// @200 tests: line, pixel count, then (x, expected pixel) pairs; line FFFF ends the list
@000
0A0C 0014 0002 0010 0502 0000 0000 0000
0A0A 0016 0000 0020 0901 0000 0000 0000
3030 0064 0000 8041 0703 0000 0000 0000
0B0C 00C8 FFFE 0038 0C00 0000 0000 0000
00FF 0000 0000 0000 0000 0000 0000 0000
0A0C 012C 0000 0020 0101 0000 0000 0000
@110
1203 F000 4560 F000 7089 F000
@120
AB00 CF00
@136
0450 F000 2300 F000
@140
50F6 1234 9999
@200
000A 0005 0014 0851 0015 0852 0016 049A 0017 0853 001A 049C
000B 0005 0014 0854 0015 0855 0016 0856 00C8 00C2 00C9 00C3
000C 0005 0014 0857 0016 0858 0017 0859 00C9 00C4 00CA 00C5
0030 0005 0064 0C74 0065 0C73 0066 0C72 0067 0C71 0068 0C76
0064 0000
00E6 0000
FFFF

// ==== testbench/obj_tb.sv ====
/* Object line engine testbench, table, ROM words and expected pixels from obj_patterns.txt
   ROM model serves bank 0 only, other banks read as end pixels */
`timescale 1ns/10ps

module obj_tb;

    localparam int         TIMEOUT  = 2000;     // Cycles allowed per line
    localparam logic [8:0] MAX_LINE = 9'd223;   // Last visible line

    logic        clk;
    logic        rst;
    logic        hstart;
    logic [8:0]  vrender;
    logic        cpu_we;
    logic [9:0]  cpu_addr;
    logic [15:0] cpu_din;
    logic [17:0] gfx_addr;
    logic [15:0] gfx_data = 16'h0000;
    logic        rd_en;
    logic [8:0]  rd_x;
    logic [11:0] rd_pix;
    logic        line_done;

    logic [15:0] pat [1024];         // Table @000, ROM @100, line tests @200
    logic [11:0] expect_pix [512];   // Whole line, zero where nothing lands
    logic [8:0]  listed [$];         // x positions named by the current test
    int          errors = 0;
    int          tests = 0;

    obj_top #(.OBJ_AW(7)) DUT (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;       // 4 ns period

    // Graphics ROM, address taken at the edge, word out one cycle later
    always @(posedge clk) begin : rom_model
        logic [17:0] a;
        a = gfx_addr;
        #1 gfx_data = (a[17:8] == '0) ? pat[{2'b01, a[7:0]}] : 16'hFFFF;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;     // Drive point after the edge
    endtask

    // Pixel is out one cycle after rd_en, entry cleared on that edge
    task automatic read_pix(input logic [8:0] x, output logic [11:0] pix);
        rd_en = 1'b1;
        rd_x  = x;
        next_cycle();
        rd_en = 1'b0;
        pix   = rd_pix;
    endtask

    task automatic load_table();
        for (int i = 0; i < 64; i++) begin
            cpu_we   = 1'b1;
            cpu_addr = i[9:0];
            cpu_din  = pat[i[9:0]];
            next_cycle();
        end
        cpu_we = 1'b0;
    endtask

    // One hstart pulse, then count cycles until line_done
    task automatic run_line(input logic [8:0] line, output logic done);
        int n;
        vrender = line;
        hstart  = 1'b1;
        next_cycle();
        hstart = 1'b0;
        done   = 1'b0;
        n      = 0;
        while (!done && n < TIMEOUT) begin
            next_cycle();
            done = line_done;
            n++;
        end
    endtask

    initial begin
        logic [9:0]  p;
        logic [9:0]  cnt;
        logic [8:0]  line;
        logic [11:0] pix;
        logic        done;
        int          err_before;
        rst      = 1'b1;
        hstart   = 1'b0;
        vrender  = 9'd0;
        cpu_we   = 1'b0;
        cpu_addr = 10'd0;
        cpu_din  = 16'h0000;
        rd_en    = 1'b0;
        rd_x     = 9'd0;
        foreach (pat[i]) pat[i] = 16'h0000;
        $readmemh("testbench/obj_patterns.txt", pat);
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        load_table();
        p = 10'h200;
        while (p < 10'd1000 && pat[p] != 16'hFFFF) begin
            line = pat[p][8:0];
            cnt  = pat[p + 10'd1][9:0];
            p    = p + 10'd2;
            foreach (expect_pix[i]) expect_pix[i] = 12'h000;
            listed.delete();
            repeat (cnt) begin
                expect_pix[pat[p][8:0]] = pat[p + 10'd1][11:0];
                listed.push_back(pat[p][8:0]);
                p = p + 10'd2;
            end
            err_before = errors;
            tests++;
            run_line(line, done);
            if (line > MAX_LINE && done) begin      // Scanner idles below the visible area
                $display("line_done pulsed for line %0d, outside the visible area", line);
                errors++;
            end else if (line <= MAX_LINE && !done) begin
                $display("Timed out after %0d cycles waiting for line_done on line %0d",
                         TIMEOUT, line);
                errors++;
            end
            for (int x = 0; x < 512; x++) begin    // Sweep also empties the buffer
                read_pix(x[8:0], pix);
                if (pix !== expect_pix[x[8:0]]) begin
                    $display("CHECK FAILED rd_pix x=%h: got %h, expected %h",
                             x[8:0], pix, expect_pix[x[8:0]]);
                    errors++;
                end
            end
            foreach (listed[k]) begin               // Already read once, now empty
                read_pix(listed[k], pix);
                if (pix !== 12'h000) begin
                    $display("CHECK FAILED rd_pix second read x=%h: got %h, expected %h",
                             listed[k], pix, 12'h000);
                    errors++;
                end
            end
            $display("Line %0d: %s", line, (errors == err_before) ? "ok" : "FAILED");
        end
        if (tests == 0) begin
            $display("No line tests were read from the pattern file");
            errors++;
        end
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
